/* project.f */
+incdir+dv
verilog/csr_pkg.sv
verilog/csr_trap_bank.sv
verilog/csr_priv_ctrl.sv
verilog/csr_read_mux.sv
verilog/csr_file_top.sv
dv/tb_csr_file.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR file testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_csr_file \
    -o tb_csr_file

./obj_dir/tb_csr_file > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

/* dv/tb_csr_checks.svh */
`ifndef TB_CSR_CHECKS_SVH
`define TB_CSR_CHECKS_SVH

// --------------------
// Compare tasks

task automatic check_word(input string name,
                          input csr_pkg::word_t actual,
                          input csr_pkg::word_t expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
        $display("Something failed");
        $fatal(1, "word mismatch");
    end
endtask

task automatic check_priv(input string name,
                          input csr_pkg::priv_t actual,
                          input csr_pkg::priv_t expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        $display("Something failed");
        $fatal(1, "privilege mismatch");
    end
endtask

task automatic check_status(input string name,
                            input csr_pkg::mstatus_t actual,
                            input csr_pkg::mstatus_t expected);
    if (actual !== expected) begin
        $display("ERROR at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
        $display("Something failed");
        $fatal(1, "status mismatch");
    end
endtask

// --------------------
// Timeout handling

task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Something failed");
    $fatal(1, "timeout");
endtask

// Polls on falling edges so the reset driver never races the check
task automatic wait_reset_release(input int max_cycles);
    int waited;
    waited = 0;
    while (rst !== 1'b0) begin
        if (waited >= max_cycles) begin
            report_timeout("reset release");
        end
        @(negedge clk);
        waited++;
    end
endtask

`endif

/* dv/tb_csr_file.sv */
`timescale 1ns/1ps

module tb_csr_file;

    localparam int unsigned HART_ID = 5;

    localparam csr_pkg::priv_t M_MODE = csr_pkg::MACHINE;
    localparam csr_pkg::priv_t S_MODE = csr_pkg::SUPERVISOR;
    localparam csr_pkg::priv_t U_MODE = csr_pkg::USER;

    localparam csr_pkg::trap_req_t  NO_TRAP = '0;
    localparam csr_pkg::trap_ret_t  NO_RET  = '0;
    localparam csr_pkg::csr_write_t NO_WR   = '0;

    // One table row, expected priv and status hold after the next edge
    typedef struct packed {
        csr_pkg::trap_req_t  trap;
        csr_pkg::trap_ret_t  ret;
        csr_pkg::csr_write_t wr;
        csr_pkg::csr_addr_t  rd_addr;
        csr_pkg::word_t      exp_rd;
        csr_pkg::word_t      exp_redirect;
        csr_pkg::priv_t      exp_priv;
        csr_pkg::mstatus_t   exp_status;
    } step_t;

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    csr_pkg::trap_req_t  trap;
    csr_pkg::trap_ret_t  ret;
    csr_pkg::csr_write_t wr;
    csr_pkg::csr_addr_t  rd_addr;
    csr_pkg::word_t      rd_data;
    csr_pkg::word_t      redirect_pc;
    csr_pkg::priv_t      priv;
    csr_pkg::mstatus_t   status;
    logic                tsr;

    step_t          steps[$];
    integer         seed;
    int             k;
    csr_pkg::word_t first_cycle;
    csr_pkg::word_t second_cycle;

    `include "tb_csr_checks.svh"

    csr_file_top #(.HART_ID(HART_ID)) UUT (
        .clk         (clk),
        .rst         (rst),
        .trap        (trap),
        .ret         (ret),
        .wr          (wr),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .redirect_pc (redirect_pc),
        .priv        (priv),
        .status      (status),
        .tsr         (tsr)
    );

    always #50 clk = ~clk;

    initial begin
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    // --------------------
    // Row builders

    function automatic csr_pkg::trap_req_t trap_request(input logic [3:0] code,
                                                        input csr_pkg::word_t value,
                                                        input csr_pkg::word_t pc);
        csr_pkg::trap_req_t req;
        req.valid              = 1'b1;
        req.cause.is_interrupt = 1'b0;
        req.cause.code         = code;
        req.value              = value;
        req.pc                 = pc;
        return req;
    endfunction

    function automatic csr_pkg::trap_ret_t return_from(input csr_pkg::priv_t level);
        csr_pkg::trap_ret_t r;
        r.valid = 1'b1;
        r.level = level;
        return r;
    endfunction

    function automatic csr_pkg::csr_write_t csr_write(input csr_pkg::csr_addr_t addr,
                                                      input csr_pkg::word_t data);
        csr_pkg::csr_write_t w;
        w.en   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    task automatic push_step(input csr_pkg::trap_req_t t, input csr_pkg::trap_ret_t r,
                             input csr_pkg::csr_write_t w, input csr_pkg::csr_addr_t addr,
                             input csr_pkg::word_t exp_rd, input csr_pkg::word_t exp_redirect,
                             input csr_pkg::priv_t exp_priv, input csr_pkg::word_t exp_status);
        step_t s;
        s.trap         = t;
        s.ret          = r;
        s.wr           = w;
        s.rd_addr      = addr;
        s.exp_rd       = exp_rd;
        s.exp_redirect = exp_redirect;
        s.exp_priv     = exp_priv;
        s.exp_status   = csr_pkg::mstatus_t'(exp_status);
        steps.push_back(s);
    endtask

    task automatic expect_read(input csr_pkg::csr_addr_t addr, input csr_pkg::word_t exp_rd,
                               input csr_pkg::priv_t exp_priv, input csr_pkg::word_t exp_status);
        push_step(NO_TRAP, NO_RET, NO_WR, addr, exp_rd, 32'h0, exp_priv, exp_status);
    endtask

    task automatic write_then_read(input csr_pkg::csr_addr_t waddr, input csr_pkg::word_t wdata,
                                   input csr_pkg::csr_addr_t raddr, input csr_pkg::word_t exp_rd,
                                   input csr_pkg::priv_t exp_priv,
                                   input csr_pkg::word_t exp_status);
        push_step(NO_TRAP, NO_RET, csr_write(waddr, wdata), raddr, exp_rd, 32'h0,
                  exp_priv, exp_status);
    endtask

    task automatic load_steps();
        // --------------------
        // Reset values and id registers
        expect_read(csr_pkg::CSR_MSTATUS, 32'h0, M_MODE, 32'h0);
        expect_read(csr_pkg::CSR_MISA, 32'h4000_0100, M_MODE, 32'h0);
        expect_read(csr_pkg::CSR_MHARTID, csr_pkg::word_t'(HART_ID), M_MODE, 32'h0);
        expect_read(12'h7C0, 32'h0, M_MODE, 32'h0);
        // --------------------
        // Write and read back, each read lags its write by one row
        write_then_read(csr_pkg::CSR_MSCRATCH, 32'h1234_5678, csr_pkg::CSR_MSCRATCH, 32'h0,
                        M_MODE, 32'h0);
        write_then_read(csr_pkg::CSR_SSCRATCH, 32'hA5A5_0001, csr_pkg::CSR_SSCRATCH, 32'h0,
                        M_MODE, 32'h0);
        write_then_read(csr_pkg::CSR_MTVEC, 32'h0000_1001, csr_pkg::CSR_MSCRATCH,
                        32'h1234_5678, M_MODE, 32'h0);
        write_then_read(csr_pkg::CSR_STVEC, 32'h0000_2000, csr_pkg::CSR_SSCRATCH,
                        32'hA5A5_0001, M_MODE, 32'h0);
        write_then_read(csr_pkg::CSR_MEDELEG, 32'h0000_0100, csr_pkg::CSR_MTVEC,
                        32'h0000_1001, M_MODE, 32'h0);
        write_then_read(csr_pkg::CSR_MEPC, 32'h0000_0400, csr_pkg::CSR_STVEC,
                        32'h0000_2000, M_MODE, 32'h0);
        write_then_read(csr_pkg::CSR_MCAUSE, 32'hFFFF_FFFF, csr_pkg::CSR_MEDELEG,
                        32'h0000_0100, M_MODE, 32'h0);
        // Status views, sstatus only reaches sie, spie and spp
        write_then_read(csr_pkg::CSR_SSTATUS, 32'hFFFF_FFFF, csr_pkg::CSR_MEPC,
                        32'h0000_0400, M_MODE, 32'h0000_0122);
        write_then_read(csr_pkg::CSR_MSTATUS, 32'hFFFF_FFFF, csr_pkg::CSR_MSTATUS,
                        32'h0000_0122, M_MODE, 32'h0040_19AA);
        write_then_read(csr_pkg::CSR_MSTATUS, 32'h0, csr_pkg::CSR_SSTATUS,
                        32'h0000_0122, M_MODE, 32'h0);
        // --------------------
        // Machine trap, the mepc write loses to the trap
        push_step(trap_request(4'd2, 32'hDEAD_BEEF, 32'h0000_0800), NO_RET,
                  csr_write(csr_pkg::CSR_MEPC, 32'h1111_1111), csr_pkg::CSR_MCAUSE,
                  32'h8000_000F, 32'h0000_1000, M_MODE, 32'h0000_1800);
        expect_read(csr_pkg::CSR_MEPC, 32'h0000_0800, M_MODE, 32'h0000_1800);
        expect_read(csr_pkg::CSR_MCAUSE, 32'h0000_0002, M_MODE, 32'h0000_1800);
        expect_read(csr_pkg::CSR_MTVAL, 32'hDEAD_BEEF, M_MODE, 32'h0000_1800);
        // mret alongside a scratch write that still lands
        push_step(NO_TRAP, return_from(M_MODE), csr_write(csr_pkg::CSR_MSCRATCH, 32'h5555_0000),
                  csr_pkg::CSR_MSTATUS, 32'h0000_1800, 32'h0000_0800, M_MODE, 32'h0);
        // Set up a drop to user mode with mpie and spp set
        write_then_read(csr_pkg::CSR_MSTATUS, 32'h0000_0180, csr_pkg::CSR_MSCRATCH,
                        32'h5555_0000, M_MODE, 32'h0000_0180);
        write_then_read(csr_pkg::CSR_MEPC, 32'h0000_3000, csr_pkg::CSR_MSTATUS,
                        32'h0000_0180, M_MODE, 32'h0000_0180);
        push_step(NO_TRAP, return_from(M_MODE), NO_WR, csr_pkg::CSR_MEPC,
                  32'h0000_3000, 32'h0000_3000, U_MODE, 32'h0000_0188);
        // --------------------
        // Delegated trap from user mode, then sret
        push_step(trap_request(4'd8, 32'h0000_0073, 32'h0000_3004), NO_RET,
                  csr_write(csr_pkg::CSR_SEPC, 32'h0000_9999), csr_pkg::CSR_SEPC,
                  32'h0, 32'h0000_2000, S_MODE, 32'h0000_0088);
        expect_read(csr_pkg::CSR_SEPC, 32'h0000_3004, S_MODE, 32'h0000_0088);
        expect_read(csr_pkg::CSR_SCAUSE, 32'h0000_0008, S_MODE, 32'h0000_0088);
        expect_read(csr_pkg::CSR_STVAL, 32'h0000_0073, S_MODE, 32'h0000_0088);
        write_then_read(csr_pkg::CSR_SSTATUS, 32'h0000_0020, csr_pkg::CSR_MEPC,
                        32'h0000_3000, S_MODE, 32'h0000_00A8);
        push_step(NO_TRAP, return_from(S_MODE), NO_WR, csr_pkg::CSR_SSTATUS,
                  32'h0000_0020, 32'h0000_3004, U_MODE, 32'h0000_00AA);
        expect_read(csr_pkg::CSR_MSTATUS, 32'h0000_00AA, U_MODE, 32'h0000_00AA);
    endtask

    // --------------------
    // Main sequence
    initial begin
        trap    = NO_TRAP;
        ret     = NO_RET;
        wr      = NO_WR;
        rd_addr = csr_pkg::CSR_CYCLE;
        seed    = 32'h49c5_34fe;
        load_steps();

        wait_reset_release(10);
        check_word("cycle after reset", rd_data, 32'h0);
        @(posedge clk);
        #1;

        foreach (steps[i]) begin
            trap    = steps[i].trap;
            ret     = steps[i].ret;
            wr      = steps[i].wr;
            rd_addr = steps[i].rd_addr;
            #48;
            check_word($sformatf("rd_data, step %0d", i), rd_data, steps[i].exp_rd);
            check_word($sformatf("redirect_pc, step %0d", i), redirect_pc,
                       steps[i].exp_redirect);
            @(posedge clk);
            #1;
            check_priv($sformatf("priv, step %0d", i), priv, steps[i].exp_priv);
            check_status($sformatf("status, step %0d", i), status, steps[i].exp_status);
            check_word($sformatf("tsr, step %0d", i), {31'd0, tsr},
                       {31'd0, steps[i].exp_status.tsr});
        end

        // Cycle counter distance over a random gap
        trap    = NO_TRAP;
        ret     = NO_RET;
        wr      = NO_WR;
        rd_addr = csr_pkg::CSR_CYCLE;
        #48;
        first_cycle = rd_data;
        k = int'({$random(seed)} % 32'd20) + 1;
        repeat (k) @(posedge clk);
        #49;
        second_cycle = rd_data;
        check_word("cycle delta", second_cycle - first_cycle, csr_pkg::word_t'(k));

        $display("Everything OK");
        $finish;
    end

endmodule

/* verilog/csr_file_top.sv */
`timescale 1ns/1ps

module csr_file_top #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::trap_req_t  trap,
    input  csr_pkg::trap_ret_t  ret,
    input  csr_pkg::csr_write_t wr,
    input  csr_pkg::csr_addr_t  rd_addr,
    output csr_pkg::word_t      rd_data,
    output csr_pkg::word_t      redirect_pc,
    output csr_pkg::priv_t      priv,
    output csr_pkg::mstatus_t   status,
    output logic                tsr
);

    csr_pkg::priv_t      trap_level;
    csr_pkg::trap_bank_t m_bank;
    csr_pkg::trap_bank_t s_bank;
    csr_pkg::word_t      medeleg;
    csr_pkg::tvec_t      mtvec;
    csr_pkg::tvec_t      stvec;

    // Trap supervisor return flag goes straight to the decoder
    assign tsr = status.tsr;

    csr_priv_ctrl u_priv_ctrl (
        .clk         (clk),
        .rst         (rst),
        .trap        (trap),
        .ret         (ret),
        .wr          (wr),
        .m_bank      (m_bank),
        .s_bank      (s_bank),
        .trap_level  (trap_level),
        .priv        (priv),
        .status      (status),
        .medeleg     (medeleg),
        .mtvec       (mtvec),
        .stvec       (stvec),
        .redirect_pc (redirect_pc)
    );

    // --------------------
    // One bank per trap level
    csr_trap_bank #(.LEVEL(csr_pkg::MACHINE)) u_m_bank (
        .clk        (clk),
        .rst        (rst),
        .trap       (trap),
        .trap_level (trap_level),
        .wr         (wr),
        .bank       (m_bank)
    );

    csr_trap_bank #(.LEVEL(csr_pkg::SUPERVISOR)) u_s_bank (
        .clk        (clk),
        .rst        (rst),
        .trap       (trap),
        .trap_level (trap_level),
        .wr         (wr),
        .bank       (s_bank)
    );

    csr_read_mux #(.HART_ID(HART_ID)) u_read_mux (
        .clk     (clk),
        .rst     (rst),
        .rd_addr (rd_addr),
        .status  (status),
        .medeleg (medeleg),
        .mtvec   (mtvec),
        .stvec   (stvec),
        .m_bank  (m_bank),
        .s_bank  (s_bank),
        .rd_data (rd_data)
    );

endmodule

/* verilog/csr_read_mux.sv */
`timescale 1ns/1ps

module csr_read_mux #(
    parameter int unsigned HART_ID = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_addr_t  rd_addr,
    input  csr_pkg::mstatus_t   status,
    input  csr_pkg::word_t      medeleg,
    input  csr_pkg::tvec_t      mtvec,
    input  csr_pkg::tvec_t      stvec,
    input  csr_pkg::trap_bank_t m_bank,
    input  csr_pkg::trap_bank_t s_bank,
    output csr_pkg::word_t      rd_data
);

    logic [63:0] cycle;

    // --------------------
    // Free running cycle counter
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // --------------------
    // Read decode, same cycle
    always_comb begin
        case (rd_addr)
            csr_pkg::CSR_SSTATUS:
                rd_data = csr_pkg::word_t'(status) & csr_pkg::SSTATUS_MASK;
            csr_pkg::CSR_STVEC:     rd_data = stvec;
            csr_pkg::CSR_SSCRATCH:  rd_data = s_bank.scratch;
            csr_pkg::CSR_SEPC:      rd_data = s_bank.epc;
            csr_pkg::CSR_SCAUSE:    rd_data = csr_pkg::cause_to_word(s_bank.cause);
            csr_pkg::CSR_STVAL:     rd_data = s_bank.tval;

            csr_pkg::CSR_MSTATUS:   rd_data = status;
            csr_pkg::CSR_MISA:      rd_data = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MEDELEG:   rd_data = medeleg;
            csr_pkg::CSR_MTVEC:     rd_data = mtvec;
            csr_pkg::CSR_MSCRATCH:  rd_data = m_bank.scratch;
            csr_pkg::CSR_MEPC:      rd_data = m_bank.epc;
            csr_pkg::CSR_MCAUSE:    rd_data = csr_pkg::cause_to_word(m_bank.cause);
            csr_pkg::CSR_MTVAL:     rd_data = m_bank.tval;

            csr_pkg::CSR_CYCLE:     rd_data = cycle[31:0];
            csr_pkg::CSR_CYCLEH:    rd_data = cycle[63:32];

            // No vendor, architecture or implementation id
            csr_pkg::CSR_MVENDORID: rd_data = '0;
            csr_pkg::CSR_MARCHID:   rd_data = '0;
            csr_pkg::CSR_MIMPID:    rd_data = '0;
            csr_pkg::CSR_MHARTID:   rd_data = csr_pkg::word_t'(HART_ID);
            default:                rd_data = '0;
        endcase
    end

endmodule

/* verilog/csr_priv_ctrl.sv */
`timescale 1ns/1ps

module csr_priv_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::trap_req_t  trap,
    input  csr_pkg::trap_ret_t  ret,
    input  csr_pkg::csr_write_t wr,
    input  csr_pkg::trap_bank_t m_bank,
    input  csr_pkg::trap_bank_t s_bank,
    output csr_pkg::priv_t      trap_level,
    output csr_pkg::priv_t      priv,
    output csr_pkg::mstatus_t   status,
    output csr_pkg::word_t      medeleg,
    output csr_pkg::tvec_t      mtvec,
    output csr_pkg::tvec_t      stvec,
    output csr_pkg::word_t      redirect_pc
);

    csr_pkg::priv_t    priv_next;
    csr_pkg::mstatus_t status_next;
    csr_pkg::word_t    sstatus_merged;

    // mpp is WARL, the reserved encoding falls back to user
    function automatic csr_pkg::mstatus_t legal_mpp(csr_pkg::mstatus_t value);
        csr_pkg::mstatus_t result;
        result = value;
        if (result.mpp == 2'b10) begin
            result.mpp = csr_pkg::USER;
        end
        return result;
    endfunction

    // Delegation looks only at the cause code
    assign trap_level = medeleg[trap.cause.code] ? csr_pkg::SUPERVISOR : csr_pkg::MACHINE;

    assign sstatus_merged = (csr_pkg::word_t'(status) & ~csr_pkg::SSTATUS_MASK)
                          | (wr.data & csr_pkg::SSTATUS_MASK);

    // --------------------
    // Next privilege and status
    always_comb begin
        priv_next   = priv;
        status_next = status;
        if (trap.valid) begin
            priv_next = trap_level;
            if (trap_level == csr_pkg::MACHINE) begin
                status_next.mpp = priv;
            end else begin
                status_next.spp = priv[0];
            end
        end else if (ret.valid) begin
            if (ret.level == csr_pkg::MACHINE) begin
                priv_next       = csr_pkg::priv_t'(status.mpp);
                status_next.mie = status.mpie;
                status_next.mpp = csr_pkg::USER;
            end else if (ret.level == csr_pkg::SUPERVISOR) begin
                priv_next       = status.spp ? csr_pkg::SUPERVISOR : csr_pkg::USER;
                status_next.sie = status.spie;
                status_next.spp = 1'b0;
            end
        end else if (wr.en && wr.addr == csr_pkg::CSR_MSTATUS) begin
            status_next = legal_mpp(csr_pkg::mstatus_t'(wr.data & csr_pkg::MSTATUS_MASK));
        end else if (wr.en && wr.addr == csr_pkg::CSR_SSTATUS) begin
            status_next = csr_pkg::mstatus_t'(sstatus_merged);
        end
    end

    // --------------------
    // Pc redirect, zero when idle
    always_comb begin
        redirect_pc = '0;
        if (trap.valid) begin
            if (trap_level == csr_pkg::MACHINE) begin
                redirect_pc = {mtvec.base, 2'b00};
            end else begin
                redirect_pc = {stvec.base, 2'b00};
            end
        end else if (ret.valid) begin
            if (ret.level == csr_pkg::MACHINE) begin
                redirect_pc = m_bank.epc;
            end else if (ret.level == csr_pkg::SUPERVISOR) begin
                redirect_pc = s_bank.epc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv    <= csr_pkg::MACHINE;
            status  <= '0;
            medeleg <= '0;
            mtvec   <= '0;
            stvec   <= '0;
        end else begin
            priv   <= priv_next;
            status <= status_next;
            if (wr.en && wr.addr == csr_pkg::CSR_MEDELEG) begin
                medeleg <= wr.data;
            end
            if (wr.en && wr.addr == csr_pkg::CSR_MTVEC) begin
                mtvec <= csr_pkg::tvec_t'(wr.data);
            end
            if (wr.en && wr.addr == csr_pkg::CSR_STVEC) begin
                stvec <= csr_pkg::tvec_t'(wr.data);
            end
        end
    end

    // Core issues traps and returns in separate cycles
    a_trap_ret_excl: assert property (@(posedge clk) disable iff (rst)
        !(trap.valid && ret.valid));

    // Reserved privilege encoding never reached
    a_priv_legal: assert property (@(posedge clk) disable iff (rst)
        priv != 2'b10);

endmodule

/* verilog/csr_trap_bank.sv */
`timescale 1ns/1ps

module csr_trap_bank #(
    parameter csr_pkg::priv_t LEVEL = csr_pkg::MACHINE
) (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::trap_req_t  trap,
    input  csr_pkg::priv_t      trap_level,
    input  csr_pkg::csr_write_t wr,
    output csr_pkg::trap_bank_t bank
);

    // --------------------
    // Address decode for this level
    localparam csr_pkg::csr_addr_t BASE =
        (LEVEL == csr_pkg::MACHINE) ? csr_pkg::CSR_MSCRATCH : csr_pkg::CSR_SSCRATCH;

    logic hit_scratch;
    logic hit_epc;
    logic hit_cause;
    logic hit_tval;
    logic capture;

    assign hit_scratch = wr.en && wr.addr == BASE;
    assign hit_epc     = wr.en && wr.addr == BASE + 12'd1;
    assign hit_cause   = wr.en && wr.addr == BASE + 12'd2;
    assign hit_tval    = wr.en && wr.addr == BASE + 12'd3;

    // Trap aimed at this level
    assign capture = trap.valid && trap_level == LEVEL;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else begin
            if (hit_scratch) begin
                bank.scratch <= wr.data;
            end
            if (capture) begin
                bank.epc   <= trap.pc;
                bank.cause <= trap.cause;
                bank.tval  <= trap.value;
            end else begin
                if (hit_epc) begin
                    bank.epc <= wr.data;
                end
                // Only the interrupt flag and the low code bits are stored
                if (hit_cause) begin
                    bank.cause <= {wr.data[31], wr.data[3:0]};
                end
                if (hit_tval) begin
                    bank.tval <= wr.data;
                end
            end
        end
    end

    a_level_legal: assert property (@(posedge clk)
        LEVEL == csr_pkg::MACHINE || LEVEL == csr_pkg::SUPERVISOR);

endmodule

/* verilog/csr_pkg.sv */
package csr_pkg;

    // --------------------
    // Widths and basic types
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // Encoding 2 is reserved and never held
    typedef enum logic [1:0] {
        USER       = 2'd0,
        SUPERVISOR = 2'd1,
        MACHINE    = 2'd3
    } priv_t;

    // --------------------
    // Register layouts
    typedef struct packed {
        logic [8:0] rsvd_31_23;
        logic       tsr;
        logic [8:0] rsvd_21_13;
        logic [1:0] mpp;
        logic [1:0] rsvd_10_9;
        logic       spp;
        logic       mpie;
        logic       rsvd_6;
        logic       spie;
        logic       rsvd_4;
        logic       mie;
        logic       rsvd_2;
        logic       sie;
        logic       rsvd_0;
    } mstatus_t;

    // Mode field is kept but only direct mode is supported
    typedef struct packed {
        logic [29:0] base;
        logic [1:0]  mode;
    } tvec_t;

    typedef struct packed {
        logic       is_interrupt;
        logic [3:0] code;
    } trap_cause_t;

    // --------------------
    // Command bundles from the core
    typedef struct packed {
        logic        valid;
        trap_cause_t cause;
        word_t       value;
        word_t       pc;
    } trap_req_t;

    typedef struct packed {
        logic  valid;
        priv_t level;
    } trap_ret_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_write_t;

    // State of one trap bank, 101 bits
    typedef struct packed {
        word_t       epc;
        trap_cause_t cause;
        word_t       tval;
        word_t       scratch;
    } trap_bank_t;

    // --------------------
    // CSR addresses
    localparam csr_addr_t CSR_SSTATUS   = 12'h100;
    localparam csr_addr_t CSR_STVEC     = 12'h105;
    localparam csr_addr_t CSR_SSCRATCH  = 12'h140;
    localparam csr_addr_t CSR_SEPC      = 12'h141;
    localparam csr_addr_t CSR_SCAUSE    = 12'h142;
    localparam csr_addr_t CSR_STVAL     = 12'h143;

    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MEDELEG   = 12'h302;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;

    localparam csr_addr_t CSR_CYCLE     = 12'hC00;
    localparam csr_addr_t CSR_CYCLEH    = 12'hC80;

    localparam csr_addr_t CSR_MVENDORID = 12'hF11;
    localparam csr_addr_t CSR_MARCHID   = 12'hF12;
    localparam csr_addr_t CSR_MIMPID    = 12'hF13;
    localparam csr_addr_t CSR_MHARTID   = 12'hF14;

    // --------------------
    // Masks and constants
    // sie, mie, spie, mpie, spp, mpp and tsr
    localparam word_t MSTATUS_MASK = 32'h0040_19AA;
    // sie, spie and spp
    localparam word_t SSTATUS_MASK = 32'h0000_0122;
    // RV32I
    localparam word_t MISA_VALUE   = 32'h4000_0100;

    // Architectural view of a stored cause
    function automatic word_t cause_to_word(trap_cause_t cause);
        return {cause.is_interrupt, 27'd0, cause.code};
    endfunction

endpackage
